/* Makefile */
VERILATOR  ?= verilator
TOP        := timeServiceTb
RTL_TOP    := timeService
FILELIST   := sources.f
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing -j 0
OBJ_DIR    := obj_dir
PASS_MSG   := Simulation completed successfully

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* hw/ppsDriver.sv */
// pps output select, local pulse restarts on each second boundary
// local pulse stays low after reset until the first boundary
module ppsDriver #(
  parameter int highTicks = 180
) (
  input  logic               CLK,
  input  logic               rst,
  input  timePkg::ppsOutMode outMode,
  input  logic               ppsSync,
  input  logic               ppsAccept,
  input  logic               ppsOk,
  input  logic               secWrap,
  output logic               ppsOut
);
  import timePkg::*;

  localparam logic [countWidth-1:0] highCount = countWidth'(highTicks);

  logic [countWidth-1:0] perCount;
  logic                  restart;
  logic                  localPulse;
  logic                  toggle;

  assign restart = ppsOk ? ppsAccept : secWrap;

  always_ff @(posedge CLK)
  begin
    if (rst)
    begin
      perCount <= highCount;
      localPulse <= 1'b0;
      toggle <= 1'b0;
    end
    else
    begin
      perCount <= restart ? '0 : perCount + 1'b1;
      localPulse <= perCount < highCount;
      // half-rate square wave
      toggle <= !toggle;
    end
  end

  always_comb
  begin
    case (outMode)
      modeDrive: ppsOut = localPulse;
      modeEcho: ppsOut = ppsSync;
      modeToggle: ppsOut = toggle;
      default: ppsOut = 1'b0;
    endcase
  end

endmodule

/* hw/ppsMonitor.sv */
// pps input sync, edge detect and acceptance window check
// ppsEdge and ppsAccept come 3 cycles after the input rises
// disablePps freezes the previous level and masks all edges
module ppsMonitor #(
  parameter int tickCount = 200,
  parameter int windowTol = 2
) (
  input  logic                              CLK,
  input  logic                              rst,
  input  logic                              ppsIn,
  input  logic                              disablePps,
  output logic                              ppsSync,
  output logic                              ppsEdge,
  output logic                              ppsAccept,
  output logic                              ppsOk,
  output logic                              ppsLost,
  output logic [timePkg::edgeWidth-1:0]     edgeCount,
  output logic [timePkg::countWidth-1:0]    ticksPerPps
);
  import timePkg::*;

  // window bounds, both exclusive
  localparam logic [countWidth-1:0] minTicks = countWidth'(tickCount - windowTol);
  localparam logic [countWidth-1:0] maxTicks = countWidth'(tickCount + windowTol);

  logic                  syncMeta;
  logic                  prevLevel;
  logic                  rawEdge;
  logic                  inWindow;
  logic [countWidth-1:0] fromRise;
  logic [countWidth-1:0] freeCount;
  logic [countWidth-1:0] freeSamp;

  assign rawEdge = ppsSync && !prevLevel && !disablePps;
  // fromRise holds the clocks elapsed since the previous edge
  assign inWindow = (fromRise > minTicks) && (fromRise < maxTicks);

  always_ff @(posedge CLK)
  begin
    if (rst)
    begin
      syncMeta <= 1'b0;
      ppsSync <= 1'b0;
      prevLevel <= 1'b0;
      fromRise <= '0;
      ppsEdge <= 1'b0;
      ppsAccept <= 1'b0;
      ppsOk <= 1'b0;
      ppsLost <= 1'b0;
      edgeCount <= '0;
      freeCount <= '0;
      freeSamp <= '0;
      ticksPerPps <= '0;
    end
    else
    begin
      syncMeta <= ppsIn;
      ppsSync <= syncMeta;
      if (!disablePps)
        prevLevel <= ppsSync;

      fromRise <= rawEdge ? countWidth'(1) : fromRise + 1'b1;
      ppsEdge <= rawEdge;
      ppsAccept <= rawEdge && inWindow;

      // ok rises the cycle after an accepted edge, drops on a loss
      ppsOk <= ppsAccept || (ppsOk && !ppsLost);
      // equality on the timeout keeps the loss a single pulse
      ppsLost <= ppsOk && ((rawEdge && !inWindow) || (fromRise == maxTicks));

      if (ppsEdge)
        edgeCount <= edgeCount + 1'b1;

      // span between accepted edges from a free-running count
      freeCount <= freeCount + 1'b1;
      if (rawEdge && inWindow)
      begin
        freeSamp <= freeCount;
        ticksPerPps <= freeCount - freeSamp;
      end
    end
  end

endmodule

/* hw/timeCommand.sv */
// command decode for the strobe-style port, one opcode per cycle, never refused
// set time goes out as a combinational strobe in the cycle the opcode is seen
// gps sticky is kept as a constant zero
module timeCommand (
  input  logic                               CLK,
  input  logic                               rst,
  input  timePkg::cmdOp                      cmd,
  input  logic [timePkg::timeWidth-1:0]      timeIn,
  input  logic [timePkg::timeWidth-1:0]      nowTime,
  input  logic                               ppsOk,
  input  logic                               ppsLost,
  output logic                               setTime,
  output logic [timePkg::controlWidth-1:0]   controlOut,
  output timePkg::ppsOutMode                 outMode,
  output logic                               disablePps,
  output logic [timePkg::stickyWidth-1:0]    stickyBits,
  output logic [timePkg::timeWidth-1:0]      deltaTime
);
  import timePkg::*;

  logic ctlWrite;
  logic clearSticky;
  logic captureDelta;
  logic timeSetSticky;
  logic ppsInSticky;
  logic ppsLostSticky;

  // opcode decode
  always_comb
  begin
    setTime = 1'b0;
    ctlWrite = 1'b0;
    clearSticky = 1'b0;
    captureDelta = 1'b0;
    case (cmd)
      opSetTime: setTime = 1'b1;
      opSetDelta: captureDelta = 1'b1;
      opSetControl: ctlWrite = 1'b1;
      opClear:
      begin
        // clear also rewrites the control word
        ctlWrite = 1'b1;
        clearSticky = 1'b1;
      end
      default: ;
    endcase
  end

  always_ff @(posedge CLK)
  begin
    if (rst)
    begin
      controlOut <= '0;
      deltaTime <= '0;
      timeSetSticky <= 1'b0;
      ppsInSticky <= 1'b0;
      ppsLostSticky <= 1'b0;
    end
    else
    begin
      if (ctlWrite)
        controlOut <= timeIn[controlWidth-1:0];
      if (captureDelta)
        deltaTime <= nowTime - timeIn;
      // clear wins over a flag raised in the same cycle
      if (clearSticky)
      begin
        timeSetSticky <= 1'b0;
        ppsInSticky <= 1'b0;
        ppsLostSticky <= 1'b0;
      end
      else
      begin
        if (setTime)
          timeSetSticky <= 1'b1;
        if (ppsOk)
          ppsInSticky <= 1'b1;
        if (ppsLost)
          ppsLostSticky <= 1'b1;
      end
    end
  end

  assign outMode = ppsOutMode'(controlOut[ctlModeLsb +: $bits(ppsOutMode)]);
  assign disablePps = controlOut[ctlDisablePps];

  // sticky bits ordered as in the top nibble of the status word
  always_comb
  begin
    stickyBits = '0;
    stickyBits[statPpsLostSticky - statTimeSetSticky] = ppsLostSticky;
    // no gps receiver here
    stickyBits[statGpsSticky - statTimeSetSticky] = 1'b0;
    stickyBits[statPpsInSticky - statTimeSetSticky] = ppsInSticky;
    stickyBits[statTimeSetSticky - statTimeSetSticky] = timeSetSticky;
  end

endmodule

/* hw/timeKeeper.sv */
// seconds count and 50-bit fraction accumulator, fixed increment
// increment is 2^48 / tickCount rounded down, no frequency servo
// nowTime lags the internal state by one register stage
module timeKeeper #(
  parameter int tickCount = 200
) (
  input  logic                             CLK,
  input  logic                             rst,
  input  logic                             setTime,
  input  logic [timePkg::timeWidth-1:0]    timeIn,
  input  logic                             ppsAccept,
  input  logic                             ppsOk,
  output logic                             secWrap,
  output logic [timePkg::timeWidth-1:0]    nowTime
);
  import timePkg::*;

  localparam int reportWidth = timeWidth - secWidth;
  localparam int padWidth = fracWidth - 2 - reportWidth;
  localparam logic [fracWidth-1:0] fracInc =
    fracWidth'((64'd1 << (fracWidth - 2)) / 64'(tickCount));

  logic [secWidth-1:0]  seconds;
  logic [fracWidth-1:0] frac;
  logic [1:0]           prevTop;
  logic                 secStep;
  logic                 ppsStep;

  // top two bits move once per second of accumulated increments
  assign secWrap = prevTop != frac[fracWidth-1 -: 2];

  // a locked pps owns the second boundary, else the local wrap does
  assign ppsStep = ppsOk && ppsAccept;
  assign secStep = ppsOk ? ppsAccept : secWrap;

  always_ff @(posedge CLK)
  begin
    if (rst)
    begin
      seconds <= '0;
      frac <= '0;
      prevTop <= '0;
      nowTime <= '0;
    end
    else
    begin
      prevTop <= frac[fracWidth-1 -: 2];

      if (setTime)
      begin
        seconds <= timeIn[timeWidth-1 -: secWidth];
        // wrap bits kept so a jam does not fake a second boundary
        frac <= {frac[fracWidth-1 -: 2], timeIn[reportWidth-1:0], {padWidth{1'b0}}};
      end
      else
      begin
        if (secStep)
          seconds <= seconds + 1'b1;
        if (ppsStep)
          frac <= {frac[fracWidth-1 -: 2], {(fracWidth - 2){1'b0}}};
        else
          frac <= frac + fracInc;
      end

      nowTime <= {seconds, frac[fracWidth-3 -: reportWidth]};
    end
  end

endmodule

/* hw/timePkg.sv */
// shared widths, control and status bit positions, command and mode enums
// one clock domain only, time values are 32-bit seconds then 32-bit fraction
package timePkg;

  localparam int secWidth = 32;
  // bits 49:48 mark the second wrap, 47:16 are the reported fraction
  localparam int fracWidth = 50;
  localparam int timeWidth = 64;
  localparam int countWidth = 28;
  localparam int edgeWidth = 8;
  localparam int controlWidth = 5;
  localparam int statusWidth = 32;

  // control word fields, bits 3 and 4 are stored only
  localparam int ctlModeLsb = 0;
  localparam int ctlDisablePps = 2;

  // status word fields
  localparam int statPpsLostSticky = 31;
  localparam int statGpsSticky = 30;
  localparam int statPpsInSticky = 29;
  localparam int statTimeSetSticky = 28;
  localparam int statPpsOk = 27;
  localparam int statPpsLost = 26;
  localparam int stickyWidth = statPpsLostSticky - statTimeSetSticky + 1;

  typedef enum logic [2:0] {
    opNone,
    opSetTime,
    opSetDelta,
    opSetControl,
    opClear
  } cmdOp;

  typedef enum logic [1:0] {
    modeDrive,
    modeEcho,
    modeToggle,
    modeOff
  } ppsOutMode;

endpackage

/* hw/timeService.sv */
// time-of-day service top, single clock domain, command acted on when sampled
// tickCount is clocks per second, 200 for simulation
// status bits 30 and 25:8 always read zero
module timeService #(
  parameter int tickCount = 200,
  parameter int windowTol = 2,
  parameter int highTicks = 180
) (
  input  logic                              CLK,
  input  logic                              rst,
  input  timePkg::cmdOp                     cmd,
  input  logic [timePkg::timeWidth-1:0]     timeIn,
  input  logic                              ppsIn,
  output logic [timePkg::statusWidth-1:0]   statusOut,
  output logic [timePkg::controlWidth-1:0]  controlOut,
  output logic [timePkg::countWidth-1:0]    ticksPerPps,
  output logic [timePkg::timeWidth-1:0]     nowTime,
  output logic [timePkg::timeWidth-1:0]     deltaTime,
  output logic                              ppsOut
);
  import timePkg::*;

  logic                   setTime;
  ppsOutMode              outMode;
  logic                   disablePps;
  logic [stickyWidth-1:0] stickyBits;
  logic                   ppsSync;
  logic                   ppsAccept;
  logic                   ppsOk;
  logic                   ppsLost;
  logic [edgeWidth-1:0]   edgeCount;
  logic                   secWrap;

  timeCommand uCommand (
    .CLK        (CLK),
    .rst        (rst),
    .cmd        (cmd),
    .timeIn     (timeIn),
    .nowTime    (nowTime),
    .ppsOk      (ppsOk),
    .ppsLost    (ppsLost),
    .setTime    (setTime),
    .controlOut (controlOut),
    .outMode    (outMode),
    .disablePps (disablePps),
    .stickyBits (stickyBits),
    .deltaTime  (deltaTime)
  );

  ppsMonitor #(
    .tickCount (tickCount),
    .windowTol (windowTol)
  ) uMonitor (
    .CLK         (CLK),
    .rst         (rst),
    .ppsIn       (ppsIn),
    .disablePps  (disablePps),
    .ppsSync     (ppsSync),
    .ppsEdge     (),
    .ppsAccept   (ppsAccept),
    .ppsOk       (ppsOk),
    .ppsLost     (ppsLost),
    .edgeCount   (edgeCount),
    .ticksPerPps (ticksPerPps)
  );

  timeKeeper #(
    .tickCount (tickCount)
  ) uKeeper (
    .CLK       (CLK),
    .rst       (rst),
    .setTime   (setTime),
    .timeIn    (timeIn),
    .ppsAccept (ppsAccept),
    .ppsOk     (ppsOk),
    .secWrap   (secWrap),
    .nowTime   (nowTime)
  );

  ppsDriver #(
    .highTicks (highTicks)
  ) uDriver (
    .CLK       (CLK),
    .rst       (rst),
    .outMode   (outMode),
    .ppsSync   (ppsSync),
    .ppsAccept (ppsAccept),
    .ppsOk     (ppsOk),
    .secWrap   (secWrap),
    .ppsOut    (ppsOut)
  );

  // status word, unused positions stay zero
  always_comb
  begin
    statusOut = '0;
    statusOut[statPpsLostSticky:statTimeSetSticky] = stickyBits;
    statusOut[statPpsOk] = ppsOk;
    statusOut[statPpsLost] = ppsLost;
    statusOut[edgeWidth-1:0] = edgeCount;
  end

endmodule

/* sources.f */
hw/timePkg.sv
hw/timeCommand.sv
hw/ppsMonitor.sv
hw/timeKeeper.sv
hw/ppsDriver.sv
hw/timeService.sv
test/tbClock.sv
test/timeServiceTb.sv

/* test/tbClock.sv */
// clock and synchronous reset source for the testbench
// reset is released with a non-blocking update on a rising edge
module tbClock #(
  parameter int period = 8,
  parameter int resetCycles = 4
) (
  output logic CLK,
  output logic rst
);

  initial
  begin
    CLK = 1'b0;
    forever #(period / 2) CLK = !CLK;
  end

  initial
  begin
    rst = 1'b1;
    repeat (resetCycles) @(posedge CLK);
    rst <= 1'b0;
  end

endmodule

/* test/timePatterns.txt */
# op operand gap expected : op 0 none 1 set time 2 delta 3 control 4 clear, hex
# gap in decimal ticks since the previous pulse, 0 for none; expected is control or seconds
3 0000000000000001 0   00000001
1 0000010000000000 0   00000100
2 0000000000001000 0   00000000
0 0000000000000000 400 00000000
0 0000000000000000 200 00000000
0 0000000000000000 200 00000103
0 0000000000000000 200 00000104
3 0000000000000003 0   00000003
0 0000000000000000 200 00000105
3 0000000000000001 0   00000001
0 0000000000000000 210 00000000
4 0000000000000001 0   00000001
0 0000000000000000 200 00000000

/* test/timeServiceTb.sv */
// pattern-driven testbench for timeService with its default parameters
// reads test/timePatterns.txt relative to the project root
// seconds are checked only where a pattern line gives a nonzero value
module timeServiceTb;
  import timePkg::*;

  localparam int tickCount = 200;
  localparam int windowTol = 2;
  localparam int pulseWidth = 5;
  localparam int maxLines = 64;

  logic                    CLK;
  logic                    rst;
  cmdOp                    cmd;
  logic [timeWidth-1:0]    timeIn;
  logic                    ppsIn;
  logic [statusWidth-1:0]  statusOut;
  logic [controlWidth-1:0] controlOut;
  logic [countWidth-1:0]   ticksPerPps;
  logic [timeWidth-1:0]    nowTime;
  logic [timeWidth-1:0]    deltaTime;
  logic                    ppsOut;

  // pattern table
  logic [2:0]  opList[maxLines];
  logic [63:0] operandList[maxLines];
  int          gapList[maxLines];
  logic [31:0] expList[maxLines];
  int          numLines;
  int          watchLimit;
  logic        loaded;

  // reference model state
  int          cyc;
  int          lastRise;
  int          lastAccept;
  int          setCyc;
  logic [31:0] setSec;
  logic [31:0] setFrac;
  logic        okModel;
  logic        lostSticky;
  logic        inSticky;
  logic        tsSticky;
  logic [7:0]  pulseCount;
  logic [4:0]  ctlModel;
  int          lostCycles;
  logic        running;
  logic        echo1;
  logic        echo2;

  tbClock #(.period(8), .resetCycles(4)) uClock (.CLK(CLK), .rst(rst));

  timeService u_dut (
    .CLK         (CLK),
    .rst         (rst),
    .cmd         (cmd),
    .timeIn      (timeIn),
    .ppsIn       (ppsIn),
    .statusOut   (statusOut),
    .controlOut  (controlOut),
    .ticksPerPps (ticksPerPps),
    .nowTime     (nowTime),
    .deltaTime   (deltaTime),
    .ppsOut      (ppsOut)
  );

  task automatic failRun(input string msg);
    $display("%s", msg);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic checkValue(input string name, input logic [63:0] got, input logic [63:0] exp);
    assert (got === exp)
    else failRun($sformatf("mismatch %s got %h expected %h", name, got, exp));
  endtask

  task automatic tick();
    @(posedge CLK);
    cyc++;
  endtask

  function automatic logic [31:0] expectedStatus();
    logic [31:0] s;
    s = '0;
    s[statPpsLostSticky] = lostSticky;
    s[statPpsInSticky] = inSticky;
    s[statTimeSetSticky] = tsSticky;
    s[statPpsOk] = okModel;
    s[edgeWidth-1:0] = pulseCount;
    return s;
  endfunction

  task automatic loadPatterns();
    int    fd;
    int    code;
    string line;
    logic [2:0]  op;
    logic [63:0] operand;
    int          gap;
    logic [31:0] exp;
    fd = $fopen("test/timePatterns.txt", "r");
    if (fd == 0)
      failRun("could not open the pattern file test/timePatterns.txt");
    numLines = 0;
    watchLimit = 200;
    while (!$feof(fd) && numLines < maxLines)
    begin
      code = $fgets(line, fd);
      if (code > 0 && line.getc(0) != 8'h23)
      begin
        if ($sscanf(line, "%h %h %d %h", op, operand, gap, exp) == 4)
        begin
          opList[numLines] = op;
          operandList[numLines] = operand;
          gapList[numLines] = gap;
          expList[numLines] = exp;
          watchLimit += gap + 20;
          numLines++;
        end
      end
    end
    $fclose(fd);
    if (numLines == 0)
      failRun("the pattern file holds no usable lines");
  endtask

  // drives one pulse whose gap counts from the previous rise
  task automatic runPulse(input int gap, input logic [31:0] expSec);
    int   t0;
    logic accept;
    logic lostExp;
    assert (cyc - lastRise <= gap)
    else failRun("a pulse gap ran out before the pulse could be driven");
    while (cyc - lastRise < gap)
      tick();
    ppsIn <= 1'b1;
    t0 = cyc;
    accept = (gap > tickCount - windowTol) && (gap < tickCount + windowTol);
    // a locked monitor reports a loss for any edge outside the window
    lostExp = okModel && !accept;
    repeat (pulseWidth) tick();
    ppsIn <= 1'b0;
    @(negedge CLK);
    pulseCount++;
    okModel = accept;
    if (lostExp)
      lostSticky = 1'b1;
    if (accept)
      inSticky = 1'b1;
    if (accept && lastAccept >= 0)
      checkValue("ticksPerPps", 64'(ticksPerPps), 64'(t0 - lastAccept));
    if (accept)
      lastAccept = t0;
    checkValue("statusOut", 64'(statusOut), 64'(expectedStatus()));
    checkValue("ppsLost cycles", 64'(lostCycles), 64'(lostExp));
    lostCycles = 0;
    if (expSec != 0)
      checkValue("nowTime seconds", 64'(nowTime[63:32]), 64'(expSec));
    lastRise = t0;
  endtask

  task automatic runCommand(input logic [2:0] op, input logic [63:0] operand,
                            input logic [31:0] expVal);
    int          m;
    logic [47:0] frac48;
    logic [63:0] seen;
    tick();
    cmd <= cmdOp'(op);
    timeIn <= operand;
    seen = '0;
    if (cmdOp'(op) == opSetDelta)
    begin
      // time as the DUT shows it just before the sampling edge
      m = cyc - setCyc - 1;
      frac48 = (48'(setFrac) << 16) + 48'(m) * 48'((64'd1 << 48) / tickCount);
      seen = {setSec, frac48[47:16]};
    end
    tick();
    cmd <= opNone;
    case (cmdOp'(op))
      opSetControl: ctlModel = expVal[4:0];
      opClear:
      begin
        ctlModel = expVal[4:0];
        lostSticky = 1'b0;
        inSticky = 1'b0;
        tsSticky = 1'b0;
      end
      opSetTime:
      begin
        tsSticky = 1'b1;
        setCyc = cyc;
        setSec = operand[63:32];
        setFrac = operand[31:0];
      end
      default: ;
    endcase
    @(negedge CLK);
    checkValue("controlOut", 64'(controlOut), 64'(ctlModel));
    checkValue("statusOut", 64'(statusOut), 64'(expectedStatus()));
    // a locked pps raises its sticky bit again right after a clear
    if (cmdOp'(op) == opClear)
      inSticky = okModel;
    if (cmdOp'(op) == opSetDelta)
      checkValue("deltaTime", deltaTime, seen - operand);
    if (cmdOp'(op) == opSetTime)
    begin
      tick();
      @(negedge CLK);
      // one edge after the load nowTime shows the operand itself
      checkValue("nowTime seconds", 64'(nowTime[63:32]), 64'(expVal));
      checkValue("nowTime fraction", 64'(nowTime[31:0]), 64'(operand[31:0]));
    end
  endtask

  // per-cycle check of echo and off modes and the zero status bits
  always @(negedge CLK)
  begin
    if (running)
    begin
      assert (statusOut[statGpsSticky] == 1'b0 && statusOut[25:8] == '0)
      else failRun("status bit 30 or bits 25:8 were set while they must read zero");
      if (ppsOutMode'(ctlModel[1:0]) == modeEcho)
      begin
        assert (ppsOut === echo2)
        else failRun($sformatf("mismatch ppsOut got %h expected %h", ppsOut, echo2));
      end
      else if (ppsOutMode'(ctlModel[1:0]) == modeOff)
      begin
        assert (ppsOut === 1'b0)
        else failRun($sformatf("mismatch ppsOut got %h expected %h", ppsOut, 1'b0));
      end
      if (statusOut[statPpsLost])
        lostCycles++;
      echo2 = echo1;
      echo1 = ppsIn;
    end
  end

  initial
  begin
    wait (loaded);
    repeat (watchLimit) @(posedge CLK);
    failRun("timeout, the pattern run did not finish in the expected time");
  end

  initial
  begin
    cmd = opNone;
    timeIn = '0;
    ppsIn = 1'b0;
    loaded = 1'b0;
    running = 1'b0;
    cyc = 0;
    lastRise = 0;
    lastAccept = -1;
    setCyc = 0;
    setSec = '0;
    setFrac = '0;
    okModel = 1'b0;
    lostSticky = 1'b0;
    inSticky = 1'b0;
    tsSticky = 1'b0;
    pulseCount = '0;
    ctlModel = '0;
    lostCycles = 0;
    echo1 = 1'b0;
    echo2 = 1'b0;
    loadPatterns();
    loaded = 1'b1;
    @(posedge CLK);
    while (rst)
      @(posedge CLK);
    // cyc 0 is the first edge out of reset
    cyc = 0;
    running = 1'b1;
    @(negedge CLK);
    checkValue("statusOut", 64'(statusOut), 64'h0);
    checkValue("controlOut", 64'(controlOut), 64'h0);
    checkValue("nowTime", nowTime, 64'h0);
    checkValue("deltaTime", deltaTime, 64'h0);
    for (int i = 0; i < numLines; i++)
    begin
      if (gapList[i] != 0)
        runPulse(gapList[i], expList[i]);
      if (opList[i] != 3'd0)
        runCommand(opList[i], operandList[i], expList[i]);
    end
    $display("Simulation completed successfully");
    $finish;
  end

endmodule
